// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;
    localparam logic [xlen-1:0] nop_inst = 32'h0000_0000;  // sll r0,r0,0

    // Major opcode field, inst[31:26]
    typedef enum logic [5:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    // Function field of SPECIAL, inst[5:0]
    typedef enum logic [5:0] {
        fn_sll  = 6'h00,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_slt  = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt,
        alu_sll,     // Shift op_b left by op_a[4:0]
        alu_pass_b
    } alu_op_e;

    typedef struct packed {
        alu_op_e               alu_op;
        logic [xlen-1:0]       op_a;
        logic [xlen-1:0]       op_b;
        logic [xlen-1:0]       st_data;    // Store value for sw
        logic [reg_addr_w-1:0] dest;
        logic                  reg_write;
        logic                  is_load;
        logic                  is_store;
        logic [xlen-1:0]       pc;
    } de_ex_t;

    typedef struct packed {
        logic [xlen-1:0]       result;     // ALU result or load address
        logic [reg_addr_w-1:0] dest;
        logic                  reg_write;
        logic                  is_load;
        logic [xlen-1:0]       pc;
    } ex_mw_t;

    typedef struct packed {
        logic                  wen;
        logic [reg_addr_w-1:0] waddr;
        logic [xlen-1:0]       wdata;
        logic [xlen-1:0]       pc;
    } wb_t;

    // What a later stage offers to decode for bypassing
    typedef struct packed {
        logic                  valid;      // Writes a nonzero register
        logic [reg_addr_w-1:0] dest;
        logic [xlen-1:0]       value;
        logic                  pending;    // Load data not yet back
    } fwd_t;

endpackage

`default_nettype wire

// File: fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     stall,
    input  logic                     redirect,          // Taken branch or j in decode
    input  logic [cpu_pkg::xlen-1:0] redirect_target,
    output logic [cpu_pkg::xlen-1:0] pc
);

    logic [cpu_pkg::xlen-1:0] pc_next;

    // The delay slot is already being fetched when decode redirects,
    // so the target replaces the fetch after it
    always_comb begin
        if (redirect) begin
            pc_next = redirect_target;
        end else if (stall) begin
            pc_next = pc;                               // Same address again next cycle
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= cpu_pkg::reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

// File: decode_stage.sv
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [cpu_pkg::xlen-1:0]       fetch_pc,
    input  logic [cpu_pkg::xlen-1:0]       inst_rdata,
    input  logic [cpu_pkg::xlen-1:0]       rs_data,
    input  logic [cpu_pkg::xlen-1:0]       rt_data,
    input  cpu_pkg::fwd_t                  ex_fwd,
    input  cpu_pkg::fwd_t                  mw_fwd,
    output logic [cpu_pkg::reg_addr_w-1:0] rs_addr,
    output logic [cpu_pkg::reg_addr_w-1:0] rt_addr,
    output logic                           stall,
    output logic                           redirect,
    output logic [cpu_pkg::xlen-1:0]       redirect_target,
    output cpu_pkg::de_ex_t                de_ex
);

    logic [cpu_pkg::xlen-1:0] pc_q;
    logic [cpu_pkg::xlen-1:0] inst_hold;     // Copy kept while stalled
    logic                     held_q;
    logic                     valid_q;
    logic [cpu_pkg::xlen-1:0] inst;
    logic [cpu_pkg::xlen-1:0] pc_plus4;
    logic [cpu_pkg::xlen-1:0] imm_sext;
    logic [cpu_pkg::xlen-1:0] rs_val;
    logic [cpu_pkg::xlen-1:0] rt_val;
    cpu_pkg::opcode_e         opcode;
    cpu_pkg::funct_e          funct;
    cpu_pkg::alu_op_e         alu_op;
    cpu_pkg::de_ex_t          de_ex_next;
    logic uses_rs, uses_rt, use_shamt, use_imm, use_lui;
    logic reg_write, is_load, is_store, is_beq, is_bne, is_j;
    logic load_hazard, branch_hazard, taken;

    // Priority is execute, then memory/writeback, then the register file
    function automatic logic [cpu_pkg::xlen-1:0] fwd_pick(
        input logic [cpu_pkg::reg_addr_w-1:0] addr,
        input logic [cpu_pkg::xlen-1:0]       rf_val
    );
        if (ex_fwd.valid && ex_fwd.dest == addr) begin
            return ex_fwd.value;
        end else if (mw_fwd.valid && mw_fwd.dest == addr) begin
            return mw_fwd.value;
        end
        return rf_val;
    endfunction

    assign inst     = !valid_q ? cpu_pkg::nop_inst : (held_q ? inst_hold : inst_rdata);
    assign opcode   = cpu_pkg::opcode_e'(inst[31:26]);
    assign funct    = cpu_pkg::funct_e'(inst[5:0]);
    assign rs_addr  = inst[25:21];
    assign rt_addr  = inst[20:16];
    assign pc_plus4 = pc_q + 32'd4;
    assign imm_sext = {{16{inst[15]}}, inst[15:0]};
    assign rs_val   = fwd_pick(rs_addr, rs_data);
    assign rt_val   = fwd_pick(rt_addr, rt_data);

    always_comb begin
        alu_op    = cpu_pkg::alu_add;
        uses_rs   = 1'b0;
        uses_rt   = 1'b0;
        use_shamt = 1'b0;
        use_imm   = 1'b0;
        use_lui   = 1'b0;
        reg_write = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_beq    = 1'b0;
        is_bne    = 1'b0;
        is_j      = 1'b0;
        case (opcode)
            cpu_pkg::op_special: begin
                uses_rs   = 1'b1;
                uses_rt   = 1'b1;
                reg_write = 1'b1;
                case (funct)
                    cpu_pkg::fn_addu: alu_op = cpu_pkg::alu_add;
                    cpu_pkg::fn_subu: alu_op = cpu_pkg::alu_sub;
                    cpu_pkg::fn_and:  alu_op = cpu_pkg::alu_and;
                    cpu_pkg::fn_or:   alu_op = cpu_pkg::alu_or;
                    cpu_pkg::fn_slt:  alu_op = cpu_pkg::alu_slt;
                    cpu_pkg::fn_sll: begin
                        alu_op    = cpu_pkg::alu_sll;
                        uses_rs   = 1'b0;
                        use_shamt = 1'b1;
                    end
                    default: reg_write = 1'b0;                  // Unsupported funct
                endcase
            end
            cpu_pkg::op_addiu: begin
                uses_rs   = 1'b1;
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            cpu_pkg::op_lui: begin
                alu_op    = cpu_pkg::alu_pass_b;
                use_lui   = 1'b1;
                reg_write = 1'b1;
            end
            cpu_pkg::op_lw: begin
                uses_rs   = 1'b1;
                use_imm   = 1'b1;
                reg_write = 1'b1;
                is_load   = 1'b1;
            end
            cpu_pkg::op_sw: begin
                uses_rs  = 1'b1;
                uses_rt  = 1'b1;
                use_imm  = 1'b1;
                is_store = 1'b1;
            end
            cpu_pkg::op_beq: begin
                uses_rs = 1'b1;
                uses_rt = 1'b1;
                is_beq  = 1'b1;
            end
            cpu_pkg::op_bne: begin
                uses_rs = 1'b1;
                uses_rt = 1'b1;
                is_bne  = 1'b1;
            end
            cpu_pkg::op_j: is_j = 1'b1;
            default: ;
        endcase
    end

    assign load_hazard = ex_fwd.valid && ex_fwd.pending
                         && ((uses_rs && ex_fwd.dest == rs_addr)
                             || (uses_rt && ex_fwd.dest == rt_addr));
    // Branch compare happens here, so an ALU result still in execute is too late
    assign branch_hazard = (is_beq || is_bne) && ex_fwd.valid
                           && (ex_fwd.dest == rs_addr || ex_fwd.dest == rt_addr);
    assign stall = load_hazard || branch_hazard;

    assign taken    = is_j || (is_beq && rs_val == rt_val) || (is_bne && rs_val != rt_val);
    assign redirect = taken && !stall;
    assign redirect_target = is_j ? {pc_plus4[31:28], inst[25:0], 2'b00}
                                  : pc_plus4 + {imm_sext[29:0], 2'b00};

    always_comb begin
        de_ex_next.alu_op    = alu_op;
        de_ex_next.op_a      = use_shamt ? {27'd0, inst[10:6]} : rs_val;
        de_ex_next.op_b      = use_lui ? {inst[15:0], 16'h0000} : (use_imm ? imm_sext : rt_val);
        de_ex_next.st_data   = rt_val;
        de_ex_next.dest      = (opcode == cpu_pkg::op_special) ? inst[15:11] : rt_addr;
        de_ex_next.reg_write = reg_write;
        de_ex_next.is_load   = is_load;
        de_ex_next.is_store  = is_store;
        de_ex_next.pc        = pc_q;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            held_q  <= 1'b0;
            de_ex   <= '0;
        end else if (stall) begin
            held_q <= 1'b1;
            de_ex  <= '0;                 // Bubble into execute
        end else begin
            valid_q <= 1'b1;
            held_q  <= 1'b0;
            de_ex   <= de_ex_next;
        end
    end

    // inst_rdata moves on during a stall, so keep the instruction locally
    always_ff @(posedge clk) begin
        if (stall) begin
            inst_hold <= inst;
        end else begin
            pc_q <= fetch_pc;
        end
    end

endmodule

`default_nettype wire

// File: reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [cpu_pkg::reg_addr_w-1:0] rs_addr,
    input  logic [cpu_pkg::reg_addr_w-1:0] rt_addr,
    input  cpu_pkg::wb_t                   wb,
    output logic [cpu_pkg::xlen-1:0]       rs_data,
    output logic [cpu_pkg::xlen-1:0]       rt_data
);

    localparam int num_regs = 2 ** cpu_pkg::reg_addr_w;

    logic [cpu_pkg::xlen-1:0] regs [num_regs];

    // Architectural state starts at zero
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.wen && wb.waddr != '0) begin
            regs[wb.waddr] <= wb.wdata;
        end
    end

    // Same-cycle write shows up on the read ports
    assign rs_data = (rs_addr == '0) ? '0
                   : (wb.wen && wb.waddr == rs_addr) ? wb.wdata : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0
                   : (wb.wen && wb.waddr == rt_addr) ? wb.wdata : regs[rt_addr];

endmodule

`default_nettype wire

// File: execute_stage.sv
`timescale 1ns/1ns
`default_nettype none

module execute_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  cpu_pkg::de_ex_t          de_ex,
    output cpu_pkg::ex_mw_t          ex_mw,
    output cpu_pkg::fwd_t            ex_fwd,
    output logic                     data_req,
    output logic                     data_wr,
    output logic [cpu_pkg::xlen-1:0] data_addr,
    output logic [cpu_pkg::xlen-1:0] data_wdata
);

    logic [cpu_pkg::xlen-1:0] alu_result;

    always_comb begin
        case (de_ex.alu_op)
            cpu_pkg::alu_add:    alu_result = de_ex.op_a + de_ex.op_b;
            cpu_pkg::alu_sub:    alu_result = de_ex.op_a - de_ex.op_b;
            cpu_pkg::alu_and:    alu_result = de_ex.op_a & de_ex.op_b;
            cpu_pkg::alu_or:     alu_result = de_ex.op_a | de_ex.op_b;
            cpu_pkg::alu_slt:    alu_result = {31'd0, $signed(de_ex.op_a) < $signed(de_ex.op_b)};
            cpu_pkg::alu_sll:    alu_result = de_ex.op_b << de_ex.op_a[4:0];
            cpu_pkg::alu_pass_b: alu_result = de_ex.op_b;      // lui
            default:             alu_result = de_ex.op_a + de_ex.op_b;
        endcase
    end

    // Memory access issues from here, data comes back in mem/wb
    assign data_req   = de_ex.is_load || de_ex.is_store;
    assign data_wr    = de_ex.is_store;
    assign data_addr  = alu_result;
    assign data_wdata = de_ex.st_data;

    assign ex_fwd.valid   = de_ex.reg_write && de_ex.dest != '0;
    assign ex_fwd.dest    = de_ex.dest;
    assign ex_fwd.value   = alu_result;
    assign ex_fwd.pending = de_ex.is_load;                     // Only an address so far

    always_ff @(posedge clk) begin
        ex_mw.result <= alu_result;
        ex_mw.dest   <= de_ex.dest;
        ex_mw.pc     <= de_ex.pc;
        if (!rst_n) begin
            ex_mw.reg_write <= 1'b0;
            ex_mw.is_load   <= 1'b0;
        end else begin
            ex_mw.reg_write <= de_ex.reg_write;
            ex_mw.is_load   <= de_ex.is_load;
        end
    end

endmodule

`default_nettype wire

// File: mem_wb_stage.sv
`timescale 1ns/1ns
`default_nettype none

module mem_wb_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  cpu_pkg::ex_mw_t          ex_mw,
    input  logic [cpu_pkg::xlen-1:0] data_rdata,
    output cpu_pkg::wb_t             wb,
    output cpu_pkg::fwd_t            mw_fwd
);

    logic [cpu_pkg::xlen-1:0] value;
    logic                     wen_next;

    // Load data arrives in this cycle, one after the request
    assign value    = ex_mw.is_load ? data_rdata : ex_mw.result;
    assign wen_next = ex_mw.reg_write && ex_mw.dest != '0;

    assign mw_fwd.valid   = wen_next;
    assign mw_fwd.dest    = ex_mw.dest;
    assign mw_fwd.value   = value;
    assign mw_fwd.pending = 1'b0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb.wen <= 1'b0;
        end else begin
            wb.wen <= wen_next;
        end
    end

    // Payload only moves with a real write, so debug ports keep the last one
    always_ff @(posedge clk) begin
        if (wen_next) begin
            wb.waddr <= ex_mw.dest;
            wb.wdata <= value;
            wb.pc    <= ex_mw.pc;
        end
    end

endmodule

`default_nettype wire

// File: cpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_top (
    input  logic                           clk,
    input  logic                           rst_n,
    output logic [cpu_pkg::xlen-1:0]       inst_addr,
    input  logic [cpu_pkg::xlen-1:0]       inst_rdata,
    output logic                           data_req,
    output logic                           data_wr,
    output logic [cpu_pkg::xlen-1:0]       data_addr,
    output logic [cpu_pkg::xlen-1:0]       data_wdata,
    input  logic [cpu_pkg::xlen-1:0]       data_rdata,
    output logic [cpu_pkg::xlen-1:0]       debug_wb_pc,
    output logic                           debug_wb_rf_wen,
    output logic [cpu_pkg::reg_addr_w-1:0] debug_wb_rf_wnum,
    output logic [cpu_pkg::xlen-1:0]       debug_wb_rf_wdata
);

    logic                           stall;
    logic                           redirect;
    logic [cpu_pkg::xlen-1:0]       redirect_target;
    logic [cpu_pkg::reg_addr_w-1:0] rs_addr;
    logic [cpu_pkg::reg_addr_w-1:0] rt_addr;
    logic [cpu_pkg::xlen-1:0]       rs_data;
    logic [cpu_pkg::xlen-1:0]       rt_data;
    cpu_pkg::de_ex_t                de_ex;
    cpu_pkg::ex_mw_t                ex_mw;
    cpu_pkg::wb_t                   wb;
    cpu_pkg::fwd_t                  ex_fwd;
    cpu_pkg::fwd_t                  mw_fwd;

    fetch_stage u_fetch (
        .clk             (clk),
        .rst_n           (rst_n),
        .stall           (stall),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .pc              (inst_addr)         // PC goes straight to instruction port
    );

    decode_stage u_decode (
        .clk             (clk),
        .rst_n           (rst_n),
        .fetch_pc        (inst_addr),
        .inst_rdata      (inst_rdata),
        .rs_data         (rs_data),
        .rt_data         (rt_data),
        .ex_fwd          (ex_fwd),
        .mw_fwd          (mw_fwd),
        .rs_addr         (rs_addr),
        .rt_addr         (rt_addr),
        .stall           (stall),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .de_ex           (de_ex)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .wb      (wb),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    execute_stage u_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .de_ex      (de_ex),
        .ex_mw      (ex_mw),
        .ex_fwd     (ex_fwd),
        .data_req   (data_req),
        .data_wr    (data_wr),
        .data_addr  (data_addr),
        .data_wdata (data_wdata)
    );

    mem_wb_stage u_mem_wb (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_mw      (ex_mw),
        .data_rdata (data_rdata),
        .wb         (wb),
        .mw_fwd     (mw_fwd)
    );

    assign debug_wb_pc       = wb.pc;
    assign debug_wb_rf_wen   = wb.wen;
    assign debug_wb_rf_wnum  = wb.waddr;
    assign debug_wb_rf_wdata = wb.wdata;

endmodule

`default_nettype wire

// File: cpu_properties.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_properties (
    input logic        clk,
    input logic        rst_n,
    input logic        data_req,
    input logic [31:0] data_addr,
    input logic        debug_wb_rf_wen,
    input logic [4:0]  debug_wb_rf_wnum
);

    // Quiet ports while held in reset
    a_reset_quiet: assert property (@(posedge clk) !rst_n |=> !debug_wb_rf_wen && !data_req)
        else $error("writeback or data request during reset");

    a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n)
        debug_wb_rf_wen |-> debug_wb_rf_wnum != 5'd0)
        else $error("writeback to r0");

    a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        data_req |-> data_addr[1:0] == 2'b00)
        else $error("unaligned data address");

endmodule

bind cpu_top cpu_properties u_props (
    .clk              (clk),
    .rst_n            (rst_n),
    .data_req         (data_req),
    .data_addr        (data_addr),
    .debug_wb_rf_wen  (debug_wb_rf_wen),
    .debug_wb_rf_wnum (debug_wb_rf_wnum)
);

`default_nettype wire

// File: tb_checker.sv
`timescale 1ns/1ns
`default_nettype none

module tb_checker (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] prog [0:255],
    input  logic [31:0] dmem_init [0:63],
    input  logic        prog_ready,
    input  logic [31:0] end_pc,
    input  logic [31:0] inst_addr,
    input  logic        data_req,
    input  logic        data_wr,
    input  logic [31:0] data_addr,
    input  logic [31:0] data_wdata,
    input  logic [31:0] debug_wb_pc,
    input  logic        debug_wb_rf_wen,
    input  logic [4:0]  debug_wb_rf_wnum,
    input  logic [31:0] debug_wb_rf_wdata,
    output logic        done,
    output int          err_wb,
    output int          err_st,
    output int          err_other
);

    logic [31:0] exp_wb_pc [$];
    logic [4:0]  exp_wb_num [$];
    logic [31:0] exp_wb_data [$];
    logic [31:0] exp_st_addr [$];
    logic [31:0] exp_st_data [$];
    logic [31:0] exp_ld_addr [$];
    logic        model_built;

    // Reference ISA run with delay slots, straight from the encodings
    task automatic run_model();
        logic [31:0] regs [0:31];
        logic [31:0] mem [0:63];
        logic [31:0] pc, npc, next, inst, a, b, sext, res;
        logic [4:0]  dst;
        bit          wr;
        int          steps;
        for (int i = 0; i < 32; i++) regs[i] = '0;
        for (int i = 0; i < 64; i++) mem[i] = dmem_init[i];
        pc    = 32'd0;
        npc   = 32'd4;
        steps = 0;
        while (pc != end_pc && steps < 5000) begin
            inst = prog[pc[9:2]];
            a    = regs[inst[25:21]];
            b    = regs[inst[20:16]];
            sext = {{16{inst[15]}}, inst[15:0]};
            next = npc + 32'd4;
            wr   = 1'b1;
            dst  = inst[20:16];
            res  = '0;
            case (inst[31:26])
                6'h00: begin
                    dst = inst[15:11];
                    case (inst[5:0])
                        6'h21:   res = a + b;
                        6'h23:   res = a - b;
                        6'h24:   res = a & b;
                        6'h25:   res = a | b;
                        6'h2a:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: res = b << inst[10:6];
                    endcase
                end
                6'h09: res = a + sext;
                6'h0f: res = {inst[15:0], 16'h0000};
                6'h23: begin
                    res = mem[5'(0) + 6'(((a + sext) >> 2) & 32'h3f)];
                    exp_ld_addr.push_back(a + sext);
                end
                6'h2b: begin
                    wr = 1'b0;
                    exp_st_addr.push_back(a + sext);
                    exp_st_data.push_back(b);
                    mem[6'((a + sext) >> 2)] = b;
                end
                6'h04, 6'h05: begin
                    wr = 1'b0;
                    if ((a == b) == (inst[31:26] == 6'h04)) next = npc + (sext << 2);
                end
                default: begin
                    wr   = 1'b0;
                    next = {npc[31:28], inst[25:0], 2'b00};
                end
            endcase
            if (wr && dst != 5'd0) begin           // r0 stays zero and never retires
                regs[dst] = res;
                exp_wb_pc.push_back(pc);
                exp_wb_num.push_back(dst);
                exp_wb_data.push_back(res);
            end
            pc  = npc;
            npc = next;
            steps++;
        end
    endtask

    function automatic bit report_mismatch(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, act);
            return 1'b1;
        end
        return 1'b0;
    endfunction

    initial begin
        int wait_cycles;
        err_wb      = 0;
        err_st      = 0;
        err_other   = 0;
        model_built = 1'b0;
        wait_cycles = 0;
        while (!prog_ready && wait_cycles < 100) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (!prog_ready) begin
            $display("ERROR: program memory was never filled");
            err_other++;
        end
        run_model();
        model_built = 1'b1;
        wait_cycles = 0;
        do begin
            @(posedge clk);
            wait_cycles++;
        end while (!rst_n && wait_cycles < 100);
        if (!rst_n) begin
            $display("ERROR: reset was never released");
            err_other++;
        end else if (report_mismatch("inst_addr", cpu_pkg::reset_pc, inst_addr)) begin
            err_other++;
        end
    end

    always @(posedge clk) begin
        if (rst_n && model_built && debug_wb_rf_wen) begin
            if (exp_wb_pc.size() == 0) begin
                $display("ERROR: t=%0t writeback from pc %h beyond the program's end",
                         $time, debug_wb_pc);
                err_other++;
            end else begin
                if (report_mismatch("debug_wb_pc", exp_wb_pc[0], debug_wb_pc)) err_wb++;
                if (report_mismatch("debug_wb_rf_wnum", 32'(exp_wb_num[0]),
                                    32'(debug_wb_rf_wnum))) err_wb++;
                if (report_mismatch("debug_wb_rf_wdata", exp_wb_data[0],
                                    debug_wb_rf_wdata)) err_wb++;
                void'(exp_wb_pc.pop_front());
                void'(exp_wb_num.pop_front());
                void'(exp_wb_data.pop_front());
            end
        end
        if (rst_n && model_built && data_req && data_wr) begin
            if (exp_st_addr.size() == 0) begin
                $display("ERROR: t=%0t store to %h that the program never makes",
                         $time, data_addr);
                err_other++;
            end else begin
                if (report_mismatch("data_addr", exp_st_addr[0], data_addr)) err_st++;
                if (report_mismatch("data_wdata", exp_st_data[0], data_wdata)) err_st++;
                void'(exp_st_addr.pop_front());
                void'(exp_st_data.pop_front());
            end
        end
        if (rst_n && model_built && data_req && !data_wr) begin
            if (exp_ld_addr.size() == 0) begin
                $display("ERROR: t=%0t load from %h that the program never makes",
                         $time, data_addr);
                err_other++;
            end else begin
                if (report_mismatch("data_addr", exp_ld_addr[0], data_addr)) err_st++;
                void'(exp_ld_addr.pop_front());
            end
        end
        done = model_built && exp_wb_pc.size() == 0 && exp_st_addr.size() == 0
               && exp_ld_addr.size() == 0;
    end

endmodule

`default_nettype wire

// File: tb_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_top;

    localparam int prog_len = 200;                 // Random part of the program
    localparam int end_idx  = prog_len;            // Index of the final self jump

    logic                           clk;
    logic                           rst_n;
    logic [cpu_pkg::xlen-1:0]       inst_addr;
    logic [cpu_pkg::xlen-1:0]       inst_rdata;
    logic                           data_req;
    logic                           data_wr;
    logic [cpu_pkg::xlen-1:0]       data_addr;
    logic [cpu_pkg::xlen-1:0]       data_wdata;
    logic [cpu_pkg::xlen-1:0]       data_rdata;
    logic [cpu_pkg::xlen-1:0]       debug_wb_pc;
    logic                           debug_wb_rf_wen;
    logic [cpu_pkg::reg_addr_w-1:0] debug_wb_rf_wnum;
    logic [cpu_pkg::xlen-1:0]       debug_wb_rf_wdata;

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:63];
    logic [31:0] dmem_init [0:63];
    logic [7:0]  i_addr_q;
    logic [5:0]  d_addr_q;
    logic [31:0] lfsr_state;
    logic        prog_ready;
    logic        done;
    int          err_wb;
    int          err_st;
    int          err_other;

    cpu_top dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .inst_addr         (inst_addr),
        .inst_rdata        (inst_rdata),
        .data_req          (data_req),
        .data_wr           (data_wr),
        .data_addr         (data_addr),
        .data_wdata        (data_wdata),
        .data_rdata        (data_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    tb_checker chk (
        .clk (clk), .rst_n (rst_n), .prog (imem), .dmem_init (dmem_init),
        .prog_ready (prog_ready), .end_pc (32'(end_idx * 4)),
        .inst_addr (inst_addr), .data_req (data_req), .data_wr (data_wr),
        .data_addr (data_addr), .data_wdata (data_wdata),
        .debug_wb_pc (debug_wb_pc), .debug_wb_rf_wen (debug_wb_rf_wen),
        .debug_wb_rf_wnum (debug_wb_rf_wnum), .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .done (done), .err_wb (err_wb), .err_st (err_st), .err_other (err_other)
    );

    // Galois LFSR, one step per bit handed out
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003)
                                       : (lfsr_state >> 1);
        end
        return r;
    endfunction

    function automatic logic [31:0] gen_inst(int i, bit no_ctrl);
        logic [3:0]  kind;
        logic [4:0]  rs, rt, rd, shamt;
        logic [15:0] imm;
        int          off;
        kind  = 4'(take_bits(4));
        rs    = 5'(take_bits(3));
        rt    = 5'(take_bits(3));
        rd    = 5'(take_bits(3));
        shamt = 5'(take_bits(5));
        imm   = 16'(take_bits(16));
        off   = int'(take_bits(3)) + 1;               // Forward 1 to 8 words
        if (i + 1 + off > end_idx) off = end_idx - i - 1;
        if (no_ctrl && kind >= 4'd13) kind = 4'd6;     // Nothing in a delay slot
        case (kind)
            4'd0:  return {6'h00, rs, rt, rd, 5'd0, 6'h21};
            4'd1:  return {6'h00, rs, rt, rd, 5'd0, 6'h23};
            4'd2:  return {6'h00, rs, rt, rd, 5'd0, 6'h24};
            4'd3:  return {6'h00, rs, rt, rd, 5'd0, 6'h25};
            4'd4:  return {6'h00, rs, rt, rd, 5'd0, 6'h2a};
            4'd5:  return {6'h00, 5'd0, rt, rd, shamt, 6'h00};
            4'd6, 4'd7: return {6'h09, rs, rt, imm};
            4'd8:  return {6'h0f, 5'd0, rt, imm};
            4'd9, 4'd10: return {6'h23, 5'd0, rt, 8'd0, imm[5:0], 2'b00};
            4'd11, 4'd12: return {6'h2b, 5'd0, rt, 8'd0, imm[5:0], 2'b00};
            4'd13: return {6'h04, rs, rt, 16'(off)};
            4'd14: return {6'h05, rs, rt, 16'(off)};
            default: return {6'h02, 26'(i + 1 + off)};
        endcase
    endfunction

    initial begin
        logic [31:0] word;
        bit          prev_ctrl;
        clk        = 1'b0;
        rst_n      = 1'b0;
        inst_rdata = '0;
        data_rdata = '0;
        prog_ready = 1'b0;
        lfsr_state = 32'd21;
        prev_ctrl  = 1'b0;
        for (int i = 0; i < 256; i++) imem[i] = cpu_pkg::nop_inst;
        for (int i = 0; i < 64; i++) begin
            dmem_init[i] = 32'hc0de_0000 ^ (32'(i) * 32'h0101_0407);
            dmem[i]      = dmem_init[i];
        end
        for (int i = 0; i < prog_len; i++) begin
            word      = gen_inst(i, prev_ctrl || i == prog_len - 1);
            imem[i]   = word;
            prev_ctrl = word[31:26] inside {6'h02, 6'h04, 6'h05};
        end
        imem[end_idx] = {6'h02, 26'(end_idx)};          // Park here forever
        prog_ready    = 1'b1;
        forever #5 clk = ~clk;
    end

    // One-cycle read latency, responses change on the falling edge
    always @(posedge clk) begin
        i_addr_q <= inst_addr[9:2];
        d_addr_q <= data_addr[7:2];
        if (rst_n && data_req && data_wr) dmem[data_addr[7:2]] <= data_wdata;
    end

    always @(negedge clk) begin
        inst_rdata <= imem[i_addr_q];
        data_rdata <= dmem[d_addr_q];
    end

    initial begin
        int  cycles;
        bit  timed_out;
        repeat (16) @(negedge clk);
        rst_n     = 1'b1;
        cycles    = 0;
        timed_out = 1'b0;
        while (!done && !timed_out) begin
            @(negedge clk);
            cycles++;
            timed_out = cycles > 20000;
        end
        repeat (20) @(negedge clk);                     // Catch stray retirements
        if (timed_out) begin
            $display("ERROR: timed out before all expected writebacks and stores were seen");
        end
        $display("errors: writeback=%0d memory=%0d other=%0d", err_wb, err_st, err_other);
        if (!timed_out && err_wb + err_st + err_other == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
cpu_pkg.sv
fetch_stage.sv
decode_stage.sv
reg_file.sv
execute_stage.sv
mem_wb_stage.sv
cpu_top.sv
cpu_properties.sv
tb_checker.sv
tb_top.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_top
FILELIST  ?= tb.f

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
